/* all.f */
+incdir+common
+incdir+verif
common/ex_types_pkg.sv
common/lsu_pkg.sv
common/ex_issue_if.sv
alu/alu.sv
verilog/ex_issue_reg.sv
verilog/branch_unit.sv
lsu/lsu.sv
verilog/ex_writeback.sv
verilog/ex_stage.sv
verif/tb_ex_stage.sv

/* verif/tb_ex_model.svh */
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// ************************************************
// stimulus record and reference model
// ************************************************
typedef struct packed {
    exec_op_t                  op;
    alu_mode_t                 mode;
    logic [`EX_XLEN-1:0]       pc;
    logic [`EX_ILEN-1:0]       inst;
    logic [`EX_XLEN-1:0]       opa;
    logic [`EX_XLEN-1:0]       opb;
    logic [`EX_REG_ADDR_W-1:0] rd;
    logic [`EX_XLEN-1:0]       src2;
    // cycle count at the edge before acceptance
    logic [31:0]               acc;
} instr_t;

logic [31:0]         lfsr;
// expected memory for the 256-byte window at 0x1000
logic [`EX_XLEN-1:0] shadow [0:31];

// fibonacci lfsr with taps 32 22 2 1
function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
endfunction

// one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[62:0], lfsr_step()};
    end
    return r;
endfunction

// start value of each doubleword from all index bits
function automatic logic [63:0] fill_word(input int idx);
    return (64'(idx) + 64'd1) * 64'h9e3779b97f4a7c15;
endfunction

function automatic logic [63:0] alu_ref(input alu_mode_t m, input logic [63:0] a, b);
    case (m)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_XOR:  return a ^ b;
        ALU_OR:   return a | b;
        ALU_AND:  return a & b;
        ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
        ALU_SLL:  return a << b[5:0];
        ALU_SRL:  return a >> b[5:0];
        default:  return $unsigned($signed(a) >>> b[5:0]);
    endcase
endfunction

function automatic logic taken_ref(input exec_op_t op, input logic [63:0] a, b);
    case (op)
        EX_BEQ:  return a == b;
        EX_BNE:  return a != b;
        EX_BLT:  return $signed(a) < $signed(b);
        EX_BGE:  return $signed(a) >= $signed(b);
        EX_BLTU: return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic int size_bytes(input exec_op_t op);
    case (op)
        EX_LB, EX_LBU, EX_SB: return 1;
        EX_LH, EX_LHU, EX_SH: return 2;
        EX_LW, EX_LWU, EX_SW: return 4;
        default:              return 8;
    endcase
endfunction

// extended value from the expected memory
function automatic logic [63:0] load_ref(input exec_op_t op, input logic [63:0] addr);
    logic [63:0] v;
    logic        sgn;
    v   = shadow[addr[7:3]] >> (addr[2:0] * 8);
    sgn = !(op inside {EX_LBU, EX_LHU, EX_LWU});
    case (size_bytes(op))
        1:       return {{56{sgn & v[7]}}, v[7:0]};
        2:       return {{48{sgn & v[15]}}, v[15:0]};
        4:       return {{32{sgn & v[31]}}, v[31:0]};
        default: return v;
    endcase
endfunction

// random fields around an aligned pc
function automatic instr_t rand_common(input exec_op_t op);
    instr_t t;
    t.op   = op;
    t.mode = alu_mode_t'(rand_bits(4) % 10);
    t.pc   = rand_bits(62) << 2;
    t.inst = 32'(rand_bits(32));
    t.opa  = rand_bits(64);
    t.opb  = rand_bits(64);
    t.rd   = 5'(rand_bits(5));
    t.src2 = rand_bits(64);
    t.acc  = '0;
    return t;
endfunction

// address split into base and offset for the alu to sum
function automatic instr_t gen_mem(input exec_op_t op, input logic [63:0] addr);
    instr_t t;
    logic [63:0] k;
    t      = rand_common(op);
    k      = rand_bits(12);
    t.mode = ALU_ADD;
    t.opa  = addr - k;
    t.opb  = k;
    return t;
endfunction

`endif

/* verif/tb_ex_stage.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module tb_ex_stage
    import ex_types_pkg::*;
();
    `include "tb_ex_model.svh"

    localparam int N_TOTAL = 300 + 200 + 400 + 100;
    localparam int LIMIT   = 8 * N_TOTAL + 10;

    logic clk = 1'b0;
    logic rst;
    logic in_valid, in_ready, out_valid, reg_wr_wen, pc_update;
    logic [`EX_XLEN-1:0] in_pc, in_opa, in_opb, in_src2, out_pc, reg_wr_value, dnpc;
    logic [`EX_ILEN-1:0] in_inst, out_inst;
    exec_op_t in_op;
    alu_mode_t in_mode;
    logic [`EX_REG_ADDR_W-1:0] in_rd, reg_wr_id;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [`EX_XLEN-1:0] wb_adr, wb_wdata, wb_rdata;
    logic [`EX_SEL_W-1:0] wb_sel;

    logic [`EX_XLEN-1:0] mem [0:31];
    instr_t pending[$];
    int cycle_count = 0;
    int errors = 0;
    int tests_failed = 0;
    int tests_run = 0;
    int n_taken = 0;
    int n_not = 0;
    int wait_cnt;
    logic busy;
    logic prev_wait = 1'b0;
    logic [136:0] prev_bus;

    ex_stage UUT (.*);

    always #10 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > LIMIT) begin
            $display("run hung, no completion within %0d cycles", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic mismatch(input string name, input logic [63:0] exp, act);
        errors++;
        $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    endtask

    task automatic complain(input string msg);
        errors++;
        $display("ERROR %s", msg);
    endtask

    // ************************************************
    // wishbone slave with 1 to 3 wait cycles
    // ************************************************
    always @(posedge clk) begin
        #1;
        if (rst) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy     = 1'b1;
                wait_cnt = 1 + int'(rand_bits(2) % 3);
            end
            if (wait_cnt == 0) begin
                wb_ack   = 1'b1;
                wb_rdata = mem[wb_adr[7:3]];
                for (int b = 0; b < 8; b++) begin
                    if (wb_we && wb_sel[b]) mem[wb_adr[7:3]][8*b +: 8] = wb_wdata[8*b +: 8];
                end
            end else begin
                wait_cnt--;
            end
        end
    end

    task automatic check_retire(input instr_t e);
        logic [63:0] a, v, exp_val, exp_pc, exp_wd, mask;
        logic [15:0] sel;
        logic exp_wen, ctrl, mem_op, st;
        int n;
        assert (out_pc == e.pc) else mismatch("out_pc", e.pc, out_pc);
        assert (out_inst == e.inst) else mismatch("out_inst", e.inst, out_inst);
        // address or jump target from the selected alu mode
        a       = alu_ref(e.mode, e.opa, e.opb);
        mem_op  = e.op inside {[EX_LB:EX_SD]};
        st      = e.op inside {[EX_SB:EX_SD]};
        exp_wen = 1'b1;
        exp_val = '0;
        case (e.op)
            EX_ALU:  exp_val = alu_ref(e.mode, e.opa, e.opb);
            EX_ALU_W: begin
                v       = alu_ref(e.mode, e.opa, e.opb);
                exp_val = {{32{v[31]}}, v[31:0]};
            end
            EX_LUI:  exp_val = e.opa;
            EX_JAL, EX_JALR: exp_val = e.pc + 64'd4;
            default: begin
                if (mem_op && !st) exp_val = load_ref(e.op, a);
                else exp_wen = 1'b0;
            end
        endcase
        assert (reg_wr_wen == exp_wen) else mismatch("reg_wr_wen", exp_wen, reg_wr_wen);
        if (exp_wen) begin
            assert (reg_wr_id == e.rd) else mismatch("reg_wr_id", e.rd, reg_wr_id);
            assert (reg_wr_value == exp_val) else mismatch("reg_wr_value", exp_val, reg_wr_value);
        end
        ctrl = e.op inside {[EX_JAL:EX_BGEU]};
        assert (pc_update == ctrl) else mismatch("pc_update", ctrl, pc_update);
        if (ctrl) begin
            if (e.op == EX_JAL) exp_pc = a;
            else if (e.op == EX_JALR) exp_pc = {a[63:1], 1'b0};
            else if (taken_ref(e.op, e.opa, e.opb)) begin
                n_taken++;
                exp_pc = e.pc + {{52{e.inst[31]}}, e.inst[7], e.inst[30:25], e.inst[11:8], 1'b0};
            end else begin
                n_not++;
                exp_pc = e.pc + 64'd4;
            end
            assert (dnpc == exp_pc) else mismatch("dnpc", exp_pc, dnpc);
        end
        if (mem_op) begin
            assert (wb_cyc && wb_ack) else complain("completion outside a bus ack cycle");
            assert (wb_adr == {a[63:3], 3'b000}) else mismatch("wb_adr", {a[63:3], 3'b0}, wb_adr);
            assert (wb_we == st) else mismatch("wb_we", st, wb_we);
            if (st) begin
                n      = size_bytes(e.op);
                sel    = ((16'd1 << n) - 16'd1) << a[2:0];
                exp_wd = e.src2 << (a[2:0] * 8);
                for (int b = 0; b < 8; b++) begin
                    mask[8*b +: 8] = {8{sel[b]}};
                    if (sel[b]) shadow[a[7:3]][8*b +: 8] = exp_wd[8*b +: 8];
                end
                assert (wb_sel == sel[7:0]) else mismatch("wb_sel", sel[7:0], wb_sel);
                assert ((wb_wdata & mask) == (exp_wd & mask))
                    else mismatch("wb_wdata", exp_wd & mask, wb_wdata & mask);
            end
        end else begin
            assert (!wb_cyc) else complain("bus cycle open for a non-memory instruction");
            assert (cycle_count == e.acc + 1) else complain("result not one cycle after acceptance");
        end
    endtask

    // ************************************************
    // monitor at mid-cycle
    // ************************************************
    always @(negedge clk) begin
        instr_t t;
        if (!rst) begin
            if (out_valid) begin
                assert (pending.size() != 0)
                    else complain("out_valid with no instruction outstanding");
                if (pending.size() != 0) check_retire(pending.pop_front());
            end
            // bus held while waiting for ack
            if (prev_wait && wb_cyc) begin
                assert ({wb_we, wb_adr, wb_sel, wb_wdata} == prev_bus)
                    else complain("bus request changed before ack");
            end
            if (wb_cyc && !wb_ack) begin
                assert (!in_ready) else complain("in_ready high while an access is pending");
            end
            prev_wait = wb_cyc & ~wb_ack;
            prev_bus  = {wb_we, wb_adr, wb_sel, wb_wdata};
            if (in_valid && in_ready) begin
                t = '{in_op, in_mode, in_pc, in_inst, in_opa, in_opb, in_rd, in_src2,
                      cycle_count};
                pending.push_back(t);
            end
        end
    end

    task automatic check_idle();
        assert (!out_valid) else complain("out_valid high in reset");
        assert (!reg_wr_wen) else complain("reg_wr_wen high in reset");
        assert (!pc_update) else complain("pc_update high in reset");
        assert (!wb_cyc && !wb_stb && !wb_we) else complain("bus cycle open in reset");
        assert (in_ready) else complain("in_ready low in reset");
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic send(input instr_t t);
        int idle;
        in_op    = t.op;
        in_mode  = t.mode;
        in_pc    = t.pc;
        in_inst  = t.inst;
        in_opa   = t.opa;
        in_opb   = t.opb;
        in_rd    = t.rd;
        in_src2  = t.src2;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        idle = int'(rand_bits(2) % 3);
        repeat (idle) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        while (pending.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic close_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("%-10s passed", name);
        end else begin
            tests_failed++;
            $display("%-10s failed, %0d errors", name, errors - mark);
        end
    endtask

    function automatic logic [63:0] rand_addr(input int n);
        return 64'h1000 | (rand_bits(8) & ~64'(n - 1));
    endfunction

    initial begin
        int mark;
        int sz;
        exec_op_t op;
        logic [63:0] addr;
        lfsr     = 32'h91ed63c4;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_pc    = '0;
        in_inst  = '0;
        in_op    = EX_NOP;
        in_opa   = '0;
        in_opb   = '0;
        in_mode  = ALU_ADD;
        in_rd    = '0;
        in_src2  = '0;
        wb_rdata = '0;
        wb_ack   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = fill_word(i);
        end
        mark = errors;
        repeat (10) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_idle();
        @(posedge clk);
        #1;
        close_test("reset", mark);

        mark = errors;
        repeat (300) send(rand_common(rand_bits(1) ? EX_ALU_W : EX_ALU));
        drain();
        close_test("alu", mark);

        // jal and jalr, then the six branches
        mark = errors;
        repeat (200) begin
            sz = int'(rand_bits(3));
            op = exec_op_t'(int'(EX_JAL) + sz);
            send(rand_bits(1) ? rand_common(op) : gen_mem(op, rand_bits(64)));
        end
        drain();
        assert (n_taken != 0 && n_not != 0)
            else complain("branches not seen both taken and not taken");
        close_test("branch", mark);

        mark = errors;
        repeat (200) begin
            sz   = int'(rand_bits(2));
            addr = rand_addr(1 << sz);
            send(gen_mem(exec_op_t'(int'(EX_SB) + sz), addr));
            op = exec_op_t'(int'(EX_LB) + int'(rand_bits(3) % 7));
            send(gen_mem(op, addr & ~64'(size_bytes(op) - 1)));
        end
        drain();
        close_test("memory", mark);

        mark = errors;
        repeat (100) begin
            op = exec_op_t'(rand_bits(5) % 23);
            if (op inside {[EX_LB:EX_SD]}) send(gen_mem(op, rand_addr(size_bytes(op))));
            else send(rand_common(op));
        end
        drain();
        close_test("mixed", mark);

        $display("tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/ex_stage.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage
    import ex_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [`EX_XLEN-1:0]       in_pc,
    input  logic [`EX_ILEN-1:0]       in_inst,
    input  exec_op_t                  in_op,
    input  logic [`EX_XLEN-1:0]       in_opa,
    input  logic [`EX_XLEN-1:0]       in_opb,
    input  alu_mode_t                 in_mode,
    input  logic [`EX_REG_ADDR_W-1:0] in_rd,
    input  logic [`EX_XLEN-1:0]       in_src2,
    output logic                      out_valid,
    output logic [`EX_XLEN-1:0]       out_pc,
    output logic [`EX_ILEN-1:0]       out_inst,
    output logic                      reg_wr_wen,
    output logic [`EX_REG_ADDR_W-1:0] reg_wr_id,
    output logic [`EX_XLEN-1:0]       reg_wr_value,
    output logic [`EX_XLEN-1:0]       dnpc,
    output logic                      pc_update,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [`EX_XLEN-1:0]       wb_adr,
    output logic [`EX_XLEN-1:0]       wb_wdata,
    output logic [`EX_SEL_W-1:0]      wb_sel,
    input  logic [`EX_XLEN-1:0]       wb_rdata,
    input  logic                      wb_ack
);

    logic                retire;
    logic                lsu_stall;
    logic [`EX_XLEN-1:0] alu_result;
    logic [`EX_XLEN-1:0] load_data;

    ex_issue_if ex_if ();

    // ************************************************
    // input register and units
    // ************************************************
    ex_issue_reg u_issue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_pc     (in_pc),
        .in_inst   (in_inst),
        .in_op     (in_op),
        .in_opa    (in_opa),
        .in_opb    (in_opb),
        .in_mode   (in_mode),
        .in_rd     (in_rd),
        .in_src2   (in_src2),
        .in_ready  (in_ready),
        .lsu_stall (lsu_stall),
        .retire    (retire),
        .issue     (ex_if.issue)
    );

    alu u_alu (
        .mode   (ex_if.mode),
        .opa    (ex_if.opa),
        .opb    (ex_if.opb),
        .result (alu_result)
    );

    branch_unit u_branch (
        .ex         (ex_if.unit),
        .alu_result (alu_result),
        .dnpc       (dnpc),
        .pc_update  (pc_update)
    );

    lsu u_lsu (
        .clk        (clk),
        .rst        (rst),
        .ex         (ex_if.unit),
        .alu_result (alu_result),
        .lsu_stall  (lsu_stall),
        .load_data  (load_data),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .wb_sel     (wb_sel),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack)
    );

    ex_writeback u_wb (
        .ex           (ex_if.unit),
        .retire       (retire),
        .alu_result   (alu_result),
        .load_data    (load_data),
        .reg_wr_wen   (reg_wr_wen),
        .reg_wr_id    (reg_wr_id),
        .reg_wr_value (reg_wr_value)
    );

    // completion and its instruction
    assign out_valid = retire;
    assign out_pc    = ex_if.pc;
    assign out_inst  = ex_if.inst;

endmodule

/* verilog/ex_writeback.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_writeback
    import ex_types_pkg::*;
(
    ex_issue_if.unit                  ex,
    input  logic                      retire,
    input  logic [`EX_XLEN-1:0]       alu_result,
    input  logic [`EX_XLEN-1:0]       load_data,
    output logic                      reg_wr_wen,
    output logic [`EX_REG_ADDR_W-1:0] reg_wr_id,
    output logic [`EX_XLEN-1:0]       reg_wr_value
);

    logic wr_class;

    // ************************************************
    // value select by op class
    // ************************************************
    always_comb begin
        wr_class = 1'b1;
        case (ex.op)
            EX_ALU:  reg_wr_value = alu_result;
            // word ops, sign-extend the low word
            EX_ALU_W: reg_wr_value = {{(`EX_XLEN-`EX_WORD_W){alu_result[`EX_WORD_W-1]}},
                                      alu_result[`EX_WORD_W-1:0]};
            // upper immediate comes in on opa
            EX_LUI:  reg_wr_value = ex.opa;
            // link address
            EX_JAL,
            EX_JALR: reg_wr_value = ex.pc + `EX_PC_STEP;
            EX_LB, EX_LH, EX_LW, EX_LD,
            EX_LBU, EX_LHU, EX_LWU: reg_wr_value = load_data;
            // stores, branches, nop
            default: begin
                wr_class     = 1'b0;
                reg_wr_value = '0;
            end
        endcase
    end

    // write only once the op completes
    assign reg_wr_wen = retire & wr_class;
    assign reg_wr_id  = ex.rd;

endmodule

/* lsu/lsu.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module lsu
    import ex_types_pkg::*;
    import lsu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    ex_issue_if.unit             ex,
    input  logic [`EX_XLEN-1:0]  alu_result,
    output logic                 lsu_stall,
    output logic [`EX_XLEN-1:0]  load_data,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [`EX_XLEN-1:0]  wb_adr,
    output logic [`EX_XLEN-1:0]  wb_wdata,
    output logic [`EX_SEL_W-1:0] wb_sel,
    input  logic [`EX_XLEN-1:0]  wb_rdata,
    input  logic                 wb_ack
);

    lsu_state_t           state;
    mem_size_t            size;
    logic                 is_mem;
    logic                 is_store;
    logic                 is_unsigned;
    logic [2:0]           offset;
    logic [5:0]           lane_shift;
    logic [`EX_XLEN-1:0]  store_data;
    logic [`EX_SEL_W-1:0] size_sel;
    logic [`EX_XLEN-1:0]  rdata_shifted;

    // ************************************************
    // op decode
    // ************************************************
    always_comb begin
        is_mem      = 1'b1;
        is_store    = 1'b0;
        is_unsigned = 1'b0;
        size        = SIZE_D;
        case (ex.op)
            EX_LB:   size = SIZE_B;
            EX_LH:   size = SIZE_H;
            EX_LW:   size = SIZE_W;
            EX_LD:   size = SIZE_D;
            EX_LBU: begin
                size        = SIZE_B;
                is_unsigned = 1'b1;
            end
            EX_LHU: begin
                size        = SIZE_H;
                is_unsigned = 1'b1;
            end
            EX_LWU: begin
                size        = SIZE_W;
                is_unsigned = 1'b1;
            end
            EX_SB: begin
                size     = SIZE_B;
                is_store = 1'b1;
            end
            EX_SH: begin
                size     = SIZE_H;
                is_store = 1'b1;
            end
            EX_SW: begin
                size     = SIZE_W;
                is_store = 1'b1;
            end
            EX_SD: begin
                size     = SIZE_D;
                is_store = 1'b1;
            end
            default: is_mem = 1'b0;
        endcase
    end

    // byte offset inside the doubleword, natural alignment assumed
    assign offset     = alu_result[2:0];
    assign lane_shift = {offset, 3'b000};

    // store data trimmed to size, selects before lane shift
    always_comb begin
        case (size)
            SIZE_B: begin
                store_data = {{(`EX_XLEN-8){1'b0}}, ex.src2[7:0]};
                size_sel   = 8'h01;
            end
            SIZE_H: begin
                store_data = {{(`EX_XLEN-16){1'b0}}, ex.src2[15:0]};
                size_sel   = 8'h03;
            end
            SIZE_W: begin
                store_data = {{(`EX_XLEN-32){1'b0}}, ex.src2[31:0]};
                size_sel   = 8'h0f;
            end
            default: begin
                store_data = ex.src2;
                size_sel   = 8'hff;
            end
        endcase
    end

    // load lanes down to bit 0, then extend
    assign rdata_shifted = wb_rdata >> lane_shift;

    always_comb begin
        case (size)
            SIZE_B: load_data = {{(`EX_XLEN-8){~is_unsigned & rdata_shifted[7]}},
                                 rdata_shifted[7:0]};
            SIZE_H: load_data = {{(`EX_XLEN-16){~is_unsigned & rdata_shifted[15]}},
                                 rdata_shifted[15:0]};
            SIZE_W: load_data = {{(`EX_XLEN-32){~is_unsigned & rdata_shifted[31]}},
                                 rdata_shifted[31:0]};
            default: load_data = rdata_shifted;
        endcase
    end

    // ************************************************
    // wishbone classic master
    // ************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LSU_IDLE;
        end else begin
            case (state)
                // open the cycle one edge after the op shows up
                LSU_IDLE: if (ex.valid && is_mem) state <= LSU_BUS;
                // close on the edge after ack
                LSU_BUS:  if (wb_ack) state <= LSU_IDLE;
                default:  state <= LSU_IDLE;
            endcase
        end
    end

    assign wb_cyc   = (state == LSU_BUS);
    assign wb_stb   = wb_cyc;
    assign wb_we    = wb_cyc & is_store;
    // doubleword aligned, lanes picked by sel
    assign wb_adr   = {alu_result[`EX_XLEN-1:3], 3'b000};
    assign wb_wdata = store_data << lane_shift;
    assign wb_sel   = size_sel << offset;

    // hold the pipeline until the slave acks
    assign lsu_stall = ex.valid & is_mem & ~(wb_cyc & wb_ack);

endmodule

/* verilog/branch_unit.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module branch_unit
    import ex_types_pkg::*;
(
    ex_issue_if.unit            ex,
    input  logic [`EX_XLEN-1:0] alu_result,
    output logic [`EX_XLEN-1:0] dnpc,
    output logic                pc_update
);

    logic [`EX_XLEN-1:0] imm_b;
    logic [`EX_XLEN-1:0] snpc;
    logic                is_branch;
    logic                is_jump;
    logic                taken;

    // b-type immediate, bit 0 always zero
    assign imm_b = {{(`EX_XLEN-12){ex.inst[31]}}, ex.inst[7], ex.inst[30:25],
                    ex.inst[11:8], 1'b0};
    assign snpc  = ex.pc + `EX_PC_STEP;

    // ************************************************
    // condition evaluation on raw operands
    // ************************************************
    always_comb begin
        is_branch = 1'b1;
        case (ex.op)
            EX_BEQ:  taken = ex.opa == ex.opb;
            EX_BNE:  taken = ex.opa != ex.opb;
            EX_BLT:  taken = $signed(ex.opa) < $signed(ex.opb);
            EX_BGE:  taken = $signed(ex.opa) >= $signed(ex.opb);
            EX_BLTU: taken = ex.opa < ex.opb;
            EX_BGEU: taken = ex.opa >= ex.opb;
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

    assign is_jump = (ex.op == EX_JAL) || (ex.op == EX_JALR);

    // target select
    always_comb begin
        case (ex.op)
            // alu already added the offset
            EX_JAL:  dnpc = alu_result;
            // jalr clears bit 0
            EX_JALR: dnpc = {alu_result[`EX_XLEN-1:1], 1'b0};
            default: dnpc = taken ? ex.pc + imm_b : snpc;
        endcase
    end

    // redirect for every control transfer, taken or not
    assign pc_update = ex.valid & (is_jump | is_branch);

endmodule

/* verilog/ex_issue_reg.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_issue_reg
    import ex_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic [`EX_XLEN-1:0]       in_pc,
    input  logic [`EX_ILEN-1:0]       in_inst,
    input  exec_op_t                  in_op,
    input  logic [`EX_XLEN-1:0]       in_opa,
    input  logic [`EX_XLEN-1:0]       in_opb,
    input  alu_mode_t                 in_mode,
    input  logic [`EX_REG_ADDR_W-1:0] in_rd,
    input  logic [`EX_XLEN-1:0]       in_src2,
    output logic                      in_ready,
    input  logic                      lsu_stall,
    output logic                      retire,
    ex_issue_if.issue                 issue
);

    logic accept;

    // slot empty, or the held op finishes this cycle
    assign in_ready = ~issue.valid | ~lsu_stall;
    assign accept   = in_valid & in_ready;

    // single completion strobe
    assign retire = issue.valid & ~lsu_stall;

    // ************************************************
    // valid bit
    // ************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            issue.valid <= 1'b0;
        end else if (accept) begin
            issue.valid <= 1'b1;
        end else if (retire) begin
            // done, nothing new behind it
            issue.valid <= 1'b0;
        end
    end

    // payload, held while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            issue.pc   <= in_pc;
            issue.inst <= in_inst;
            issue.op   <= in_op;
            issue.opa  <= in_opa;
            issue.opb  <= in_opb;
            issue.mode <= in_mode;
            issue.rd   <= in_rd;
            issue.src2 <= in_src2;
        end
    end

endmodule

/* alu/alu.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module alu
    import ex_types_pkg::*;
(
    input  alu_mode_t           mode,
    input  logic [`EX_XLEN-1:0] opa,
    input  logic [`EX_XLEN-1:0] opb,
    output logic [`EX_XLEN-1:0] result
);

    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   lt_signed;
    logic                   lt_unsigned;

    // only the low bits of opb count for shifts
    assign shamt = opb[`EX_SHAMT_W-1:0];

    // compares for the set-less-than modes
    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    always_comb begin
        case (mode)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_OR:   result = opa | opb;
            ALU_AND:  result = opa & opb;
            // 0 or 1
            ALU_SLT:  result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:  result = opa << shamt;
            ALU_SRL:  result = opa >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result = $unsigned($signed(opa) >>> shamt);
            default:  result = '0;
        endcase
    end

endmodule

/* common/ex_issue_if.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

// registered instruction, fanned out to the units
interface ex_issue_if
    import ex_types_pkg::*;
();
    logic                      valid;
    logic [`EX_XLEN-1:0]       pc;
    logic [`EX_ILEN-1:0]       inst;
    exec_op_t                  op;
    // operands already picked by decode
    logic [`EX_XLEN-1:0]       opa;
    logic [`EX_XLEN-1:0]       opb;
    alu_mode_t                 mode;
    logic [`EX_REG_ADDR_W-1:0] rd;
    // store data
    logic [`EX_XLEN-1:0]       src2;

    // pipeline register side
    modport issue (output valid, pc, inst, op, opa, opb, mode, rd, src2);

    // consumers
    modport unit (input valid, pc, inst, op, opa, opb, mode, rd, src2);

endinterface

/* common/lsu_pkg.sv */
package lsu_pkg;

    // access size of a load or store
    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W,
        SIZE_D
    } mem_size_t;

    // bus master state
    // idle, or one classic cycle open until ack
    typedef enum logic [0:0] {
        LSU_IDLE,
        LSU_BUS
    } lsu_state_t;

endpackage

/* common/ex_types_pkg.sv */
package ex_types_pkg;

    // ************************************************
    // operation class, decoded upstream
    // ************************************************
    typedef enum logic [4:0] {
        EX_NOP,
        // register/immediate arithmetic
        EX_ALU,
        EX_ALU_W,
        EX_LUI,
        // jumps
        EX_JAL,
        EX_JALR,
        // conditional branches
        EX_BEQ,
        EX_BNE,
        EX_BLT,
        EX_BGE,
        EX_BLTU,
        EX_BGEU,
        // loads, signed then unsigned
        EX_LB,
        EX_LH,
        EX_LW,
        EX_LD,
        EX_LBU,
        EX_LHU,
        EX_LWU,
        // stores
        EX_SB,
        EX_SH,
        EX_SW,
        EX_SD
    } exec_op_t;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_mode_t;

endpackage

/* common/ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// ************************************************
// execute stage widths and constants
// ************************************************

// data and pc width, two 32-bit words
`define EX_XLEN        64
// raw instruction width
`define EX_ILEN        32
// register index
`define EX_REG_ADDR_W  5
// wishbone byte selects, one per data byte
`define EX_SEL_W       8
// shift amount for 64-bit shifts
`define EX_SHAMT_W     6
// sequential pc increment
`define EX_PC_STEP     4
// word op result width
`define EX_WORD_W      32

`endif
